//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbNode
RTL_TOP   ?= nodeCore
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

SOURCES   := $(wildcard hw/*.sv sim/*.sv sim/*.svh)
RTL_FILES := $(shell grep '^hw/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
+incdir+sim
hw/nodePkg.sv
hw/progStore.sv
hw/instrDecode.sv
hw/commPorts.sv
hw/execUnit.sv
hw/seqUnit.sv
hw/nodeCore.sv
sim/tbNode.sv

//--- hw/commPorts.sv
module commPorts (
   input  logic             clk,
   input  logic             rst,
   input  nodePkg::decodedT dec,
   input  nodePkg::valueT   operand,
   input  nodePkg::linkInT  linkIn,
   input  nodePkg::dirT     wready,
   output nodePkg::linkOutT linkOut,
   output nodePkg::valueT   portData,
   output logic             step
);
   import nodePkg::*;

   typedef enum logic {
      stIdle,
      stWriting
   } stateE;

   stateE      state;
   logic [2:0] srcCode;
   logic [2:0] dstCode;
   logic       isPortSrc;
   logic       isPortDst;
   logic       srcReady;
   logic       loadOut;
   logic       writeDone;
   dirT        srcSel;
   dirT        dstSel;
   dirT        readVec;
   dirT        writeReg;
   valueT      outReg;

   assign srcCode   = dec.src;
   assign dstCode   = dec.dst;
   assign isPortSrc = srcCode[2];  // Port codes 4..7
   assign isPortDst = dstCode[2];

   assign srcSel = isPortSrc ? dirT'(4'b0001 << srcCode[1:0]) : '0;
   assign dstSel = isPortDst ? dirT'(4'b0001 << dstCode[1:0]) : '0;

   assign srcReady = !isPortSrc || ((srcSel & linkIn.rready) != '0);
   assign portData = linkIn.data[srcCode[1:0]];

   // Source word is consumed once, before any write goes out
   assign readVec = (state == stIdle) ? (srcSel & linkIn.rready) : '0;

   assign loadOut   = (state == stIdle) && isPortDst && srcReady;
   assign writeDone = (state == stWriting) && ((writeReg & wready) != '0);

   assign step = ((state == stIdle) && !isPortDst && srcReady) || writeDone;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= stIdle;
         writeReg <= '0;
         outReg   <= '0;
      end else if (loadOut) begin
         state    <= stWriting;
         writeReg <= dstSel;
         outReg   <= operand;
      end else if (writeDone) begin
         state    <= stIdle;
         writeReg <= '0;  // out keeps the last word
      end
   end

   assign linkOut = '{
      write: writeReg,
      read:  readVec,
      out:   outReg
   };

endmodule

//--- hw/execUnit.sv
module execUnit (
   input  logic             clk,
   input  logic             rst,
   input  logic             step,
   input  nodePkg::decodedT dec,
   input  nodePkg::valueT   portData,
   output nodePkg::valueT   operand,
   output nodePkg::valueT   acc
);
   import nodePkg::*;

   localparam logic signed [11:0] wideMax = 12'(valueMax);

   valueT              bak;
   logic signed [11:0] sum;
   logic signed [11:0] diff;
   logic signed [11:0] negAcc;

   function automatic valueT satValue(input logic signed [11:0] v);
      if (v > wideMax) begin
         return valueT'(valueMax);
      end else if (v < -wideMax) begin
         return -valueT'(valueMax);
      end
      return valueT'(v);
   endfunction

   always_comb begin
      case (dec.src)
         srcLit:  operand = dec.lit;
         srcNil:  operand = '0;
         srcAcc:  operand = acc;
         default: operand = portData;
      endcase
   end

   assign sum    = 12'(acc) + 12'(operand);
   assign diff   = 12'(acc) - 12'(operand);  // SUB ACC lands on zero
   assign negAcc = -12'(acc);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc <= '0;
         bak <= '0;
      end else if (step) begin
         case (dec.op)
            opMov: begin
               if (dec.dst == dstAcc) begin
                  acc <= satValue(12'(operand));
               end
            end
            opAdd: acc <= satValue(sum);
            opSub: acc <= satValue(diff);
            opNeg: acc <= satValue(negAcc);
            opSwp: begin
               acc <= bak;
               bak <= acc;
            end
            opSav: bak <= acc;
            default: ;
         endcase
      end
   end

endmodule

//--- hw/instrDecode.sv
module instrDecode (
   input  nodePkg::instrT   instr,
   output nodePkg::decodedT dec
);
   import nodePkg::*;

   valueT       field;
   logic        isLit;
   logic [10:0] code;
   srcE         srcKind;
   dstE         dstKind;

   assign field = valueT'(instr[10:0]);
   assign isLit = field <= valueT'(valueMax);
   assign code  = instr[10:0] - 11'(portBase);

   // ANY, LAST and unused codes fall back to NIL
   always_comb begin
      srcKind = srcNil;
      if (isLit) begin
         srcKind = srcLit;
      end else begin
         case (code)
            11'd1:   srcKind = srcAcc;
            11'd4:   srcKind = srcLeft;
            11'd5:   srcKind = srcRight;
            11'd6:   srcKind = srcUp;
            11'd7:   srcKind = srcDown;
            default: srcKind = srcNil;
         endcase
      end
   end

   always_comb begin
      case (instr[13:11])
         3'd1:    dstKind = dstAcc;
         3'd4:    dstKind = dstLeft;
         3'd5:    dstKind = dstRight;
         3'd6:    dstKind = dstUp;
         3'd7:    dstKind = dstDown;
         default: dstKind = dstNil;
      endcase
   end

   always_comb begin
      dec.op     = opNop;
      dec.src    = srcNil;
      dec.dst    = dstNil;
      dec.lit    = field;
      dec.target = instr[3:0];
      if (!instr[14]) begin
         dec.op  = opMov;
         dec.src = srcKind;
         dec.dst = dstKind;
      end else begin
         case (instr[13:11])
            3'd4: begin
               dec.op  = opAdd;
               dec.src = srcKind;
            end
            3'd5: begin
               dec.op  = opSub;
               dec.src = srcKind;
            end
            3'd6: begin
               dec.op  = opJro;
               dec.src = srcKind;
            end
            3'd7: begin
               case (instr[10:4])
                  7'h7A:   dec.op = opJmp;
                  7'h7B:   dec.op = opJez;
                  7'h7C:   dec.op = opJnz;
                  7'h7D:   dec.op = opJgz;
                  7'h7E:   dec.op = opJlz;
                  7'h7F: begin
                     case (instr[3:0])
                        4'hC:    dec.op = opSwp;
                        4'hD:    dec.op = opSav;
                        4'hE:    dec.op = opNeg;
                        default: dec.op = opNop;
                     endcase
                  end
                  default: dec.op = opNop;
               endcase
            end
            default: dec.op = opNop;
         endcase
      end
   end

endmodule

//--- hw/nodeCore.sv
module nodeCore #(
   parameter int progDepth = 15  // 2 to 16 words
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             load,
   input  nodePkg::pcT      loadAddr,
   input  nodePkg::instrT   loadData,
   input  nodePkg::pcT      loadLength,
   input  nodePkg::linkInT  linkIn,
   input  nodePkg::dirT     wready,
   output nodePkg::linkOutT linkOut
);
   import nodePkg::*;

   instrT   instr;
   pcT      progLength;
   pcT      pc;
   decodedT dec;
   valueT   operand;
   valueT   acc;
   valueT   portData;
   logic    step;

   progStore #(
      .progDepth (progDepth)
   ) u_progStore (
      .clk        (clk),
      .load       (load),
      .loadAddr   (loadAddr),
      .loadData   (loadData),
      .loadLength (loadLength),
      .pc         (pc),
      .instr      (instr),
      .progLength (progLength)
   );

   instrDecode u_instrDecode (
      .instr (instr),
      .dec   (dec)
   );

   commPorts u_commPorts (
      .clk      (clk),
      .rst      (rst),
      .dec      (dec),
      .operand  (operand),
      .linkIn   (linkIn),
      .wready   (wready),
      .linkOut  (linkOut),
      .portData (portData),
      .step     (step)
   );

   execUnit u_execUnit (
      .clk      (clk),
      .rst      (rst),
      .step     (step),
      .dec      (dec),
      .portData (portData),
      .operand  (operand),
      .acc      (acc)
   );

   seqUnit #(
      .progDepth (progDepth)
   ) u_seqUnit (
      .clk        (clk),
      .rst        (rst),
      .step       (step),
      .dec        (dec),
      .operand    (operand),
      .acc        (acc),
      .progLength (progLength),
      .pc         (pc)
   );

endmodule

//--- hw/nodePkg.sv
package nodePkg;

   localparam int valueMax = 999;   // Saturation limit of acc and bak
   localparam int portBase = 1000;  // First source code that is not a literal

   typedef logic signed [10:0] valueT;
   typedef logic [15:0]        instrT;
   typedef logic [3:0]         pcT;
   typedef logic [3:0]         dirT;    // Bit 0 left, 1 right, 2 up, 3 down

   // SWP/SAV/NEG/NOP group with code 1111, also returned past the program end
   localparam instrT nopWord = 16'h7FFF;

   // Port kinds share the low two bits with the direction index
   typedef enum logic [2:0] {
      srcLit   = 3'd0,
      srcNil   = 3'd1,
      srcAcc   = 3'd2,
      srcLeft  = 3'd4,
      srcRight = 3'd5,
      srcUp    = 3'd6,
      srcDown  = 3'd7
   } srcE;

   typedef enum logic [2:0] {
      dstNil   = 3'd0,
      dstAcc   = 3'd1,
      dstLeft  = 3'd4,
      dstRight = 3'd5,
      dstUp    = 3'd6,
      dstDown  = 3'd7
   } dstE;

   typedef enum logic [3:0] {
      opMov, opAdd, opSub, opJro,
      opJmp, opJez, opJnz, opJgz, opJlz,
      opSwp, opSav, opNeg, opNop
   } opE;

   typedef struct packed {
      opE    op;
      srcE   src;
      dstE   dst;
      valueT lit;     // Signed literal, valid for srcLit
      pcT    target;  // Absolute jump target
   } decodedT;

   typedef struct packed {
      dirT             rready;
      valueT [3:0]     data;    // Indexed like dirT
   } linkInT;

   typedef struct packed {
      dirT   write;
      dirT   read;
      valueT out;
   } linkOutT;

endpackage

//--- hw/progStore.sv
module progStore #(
   parameter int progDepth = 15
) (
   input  logic           clk,
   input  logic           load,
   input  nodePkg::pcT    loadAddr,
   input  nodePkg::instrT loadData,
   input  nodePkg::pcT    loadLength,
   input  nodePkg::pcT    pc,
   output nodePkg::instrT instr,
   output nodePkg::pcT    progLength
);
   import nodePkg::*;

   localparam logic [4:0] depth5 = 5'(progDepth);

   instrT mem [progDepth];
   pcT    lengthReg;   // Zero selects the whole store
   logic  inRange;

   always_ff @(posedge clk) begin
      if (load) begin
         if ({1'b0, loadAddr} < depth5) begin
            mem[loadAddr] <= loadData;
         end
         if ({1'b0, loadLength} > depth5) begin
            lengthReg <= pcT'(depth5);
         end else begin
            lengthReg <= loadLength;
         end
      end
   end

   assign inRange = ({1'b0, pc} < depth5) && ((lengthReg == '0) || (pc < lengthReg));

   assign instr      = inRange ? mem[pc] : nopWord;  // Idle slot past the program
   assign progLength = lengthReg;

endmodule

//--- hw/seqUnit.sv
module seqUnit #(
   parameter int progDepth = 15
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             step,
   input  nodePkg::decodedT dec,
   input  nodePkg::valueT   operand,
   input  nodePkg::valueT   acc,
   input  nodePkg::pcT      progLength,
   output nodePkg::pcT      pc
);
   import nodePkg::*;

   localparam logic [4:0] depth5 = 5'(progDepth);

   logic [4:0]         effLen;
   pcT                 lastPc;
   pcT                 pcInc;
   pcT                 jroPc;
   logic signed [11:0] jroSum;
   logic               takeJump;

   // Length zero or above the store means the full store
   assign effLen = ((progLength == '0) || ({1'b0, progLength} > depth5)) ?
                   depth5 : {1'b0, progLength};
   assign lastPc = pcT'(effLen - 5'd1);
   assign pcInc  = (pc >= lastPc) ? '0 : pc + 4'd1;

   assign jroSum = $signed({8'd0, pc}) + 12'(operand);

   always_comb begin
      if (dec.src == srcNil) begin
         jroPc = '0;  // JRO NIL restarts
      end else if (jroSum < 12'sd0) begin
         jroPc = '0;
      end else if (jroSum > $signed({8'd0, lastPc})) begin
         jroPc = lastPc;
      end else begin
         jroPc = pcT'(jroSum);
      end
   end

   always_comb begin
      case (dec.op)
         opJmp:   takeJump = 1'b1;
         opJez:   takeJump = (acc == valueT'(0));
         opJnz:   takeJump = (acc != valueT'(0));
         opJgz:   takeJump = (acc > valueT'(0));
         opJlz:   takeJump = (acc < valueT'(0));
         default: takeJump = 1'b0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pc <= '0;
      end else if (step) begin
         if (dec.op == opJro) begin
            pc <= jroPc;
         end else if (takeJump) begin
            pc <= dec.target;
         end else begin
            pc <= pcInc;
         end
      end
   end

endmodule

//--- sim/tbNodeTasks.svh
localparam dirT dirLeft  = 4'b0001;
localparam dirT dirRight = 4'b0010;
localparam dirT dirUp    = 4'b0100;
localparam dirT dirDown  = 4'b1000;

localparam logic [10:0] fAcc  = 11'd1001;  // Source field codes above the literals
localparam logic [10:0] fLeft = 11'd1004;
localparam logic [2:0]  kAdd  = 3'd4;
localparam logic [2:0]  kSub  = 3'd5;
localparam logic [2:0]  kJro  = 3'd6;
localparam logic [6:0]  jJmp  = 7'h7A;
localparam logic [6:0]  jJez  = 7'h7B;
localparam logic [6:0]  jJnz  = 7'h7C;
localparam logic [6:0]  jJgz  = 7'h7D;
localparam logic [6:0]  jJlz  = 7'h7E;
localparam instrT swpI = 16'h7FFC;
localparam instrT savI = 16'h7FFD;
localparam instrT negI = 16'h7FFE;

function automatic logic [10:0] litF(input int v);
   return v[10:0];
endfunction

function automatic instrT movI(input logic [2:0] dst, input logic [10:0] src);
   return {2'b00, dst, src};
endfunction

function automatic instrT aluI(input logic [2:0] kind, input logic [10:0] src);
   return {2'b01, kind, src};
endfunction

function automatic instrT jumpI(input logic [6:0] kind, input int target);
   return {2'b01, 3'd7, kind, target[3:0]};
endfunction

function automatic int satModel(input int v);
   if (v > 999) begin
      return 999;
   end else if (v < -999) begin
      return -999;
   end
   return v;
endfunction

function automatic logic [31:0] lfsrNext(input logic [31:0] s);
   if (s[0]) begin
      return (s >> 1) ^ 32'hA3000000;  // Galois taps 32, 30, 26, 25
   end
   return s >> 1;
endfunction

function automatic int randValue();
   logic [10:0] bits;
   int          i;
   for (i = 0; i < 11; i++) begin
      lfsrState = lfsrNext(lfsrState);
      bits[i]   = lfsrState[0];
   end
   return satModel(int'($signed(bits)));
endfunction

task automatic checkValue(input string name, input valueT got, input valueT exp);
   if (got !== exp) begin
      valueErrs++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
   end
endtask

task automatic checkDir(input string name, input dirT got, input dirT exp);
   if (got !== exp) begin
      dirErrs++;
      $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
   end
endtask

task automatic checkPc(input string name, input pcT got, input pcT exp);
   if (got !== exp) begin
      pcErrs++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
   end
endtask

// Program goes in while rst is high, reset is released after the last word
task automatic loadProgram(input int len);
   int i;
   @(posedge clk);
   rst    <= 1'b1;
   linkIn <= '0;
   wready <= '0;
   for (i = 0; i < len; i++) begin
      @(posedge clk);
      load       <= 1'b1;
      loadAddr   <= pcT'(i);
      loadData   <= progBuf[i];
      loadLength <= pcT'(len);
   end
   @(posedge clk);
   load <= 1'b0;
   @(negedge clk);
   checkPc("progLength", u_nodeCore.progLength, pcT'(len));
   @(posedge clk);
   rst <= 1'b0;
endtask

task automatic offerWord(input int d, input valueT v, input int preDelay);
   int waited;
   waited = 0;
   repeat (preDelay) begin
      @(negedge clk);
      checkDir("linkOut.read", linkOut.read, '0);  // Nothing offered yet
   end
   @(posedge clk);
   linkIn.rready[d] <= 1'b1;
   linkIn.data[d]   <= v;
   @(negedge clk);
   while (linkOut.read[d] !== 1'b1 && waited < maxWait) begin
      @(negedge clk);
      waited++;
   end
   if (linkOut.read[d] !== 1'b1) begin
      waitErrs++;
      $display("Timeout at %0t: the word on port %0d was never read", $time, d);
   end else begin
      checkDir("linkOut.read", linkOut.read, dirT'(1 << d));
   end
   @(posedge clk);
   linkIn.rready[d] <= 1'b0;
   @(negedge clk);
   checkDir("linkOut.read", linkOut.read, '0);
endtask

task automatic awaitWrite(input dirT dir, input valueT exp, input int delay);
   int waited;
   waited = 0;
   @(negedge clk);
   while (linkOut.write == '0 && waited < maxWait) begin
      @(negedge clk);
      waited++;
   end
   if (linkOut.write == '0) begin
      waitErrs++;
      $display("Timeout at %0t: no write came out, expected value %0d", $time, exp);
      return;
   end
   checkDir("linkOut.write", linkOut.write, dir);
   checkValue("linkOut.out", linkOut.out, exp);
   repeat (delay) begin
      @(negedge clk);
      checkDir("linkOut.write", linkOut.write, dir);  // Held under back-pressure
      checkValue("linkOut.out", linkOut.out, exp);
   end
   @(posedge clk);
   wready <= dir;
   @(negedge clk);
   checkDir("linkOut.write", linkOut.write, dir);
   @(posedge clk);
   wready <= '0;
   @(negedge clk);
   checkDir("linkOut.write", linkOut.write, '0);
endtask

//--- sim/tbNode.sv
module tbNode;
   import nodePkg::*;

   localparam int period     = 40;
   localparam int maxWait    = 60;
   localparam int testCycles = 40 + 120 + 160 + 420 + 200;  // Idle, literal, add, sat, flow
   localparam int margin     = 4000;

   logic        clk;
   logic        rst;
   logic        load;
   pcT          loadAddr;
   instrT       loadData;
   pcT          loadLength;
   linkInT      linkIn;
   dirT         wready;
   linkOutT     linkOut;
   int          valueErrs;
   int          dirErrs;
   int          pcErrs;
   int          waitErrs;
   logic [31:0] lfsrState;
   instrT       progBuf [16];

   nodeCore #(
      .progDepth (15)
   ) u_nodeCore (
      .clk        (clk),
      .rst        (rst),
      .load       (load),
      .loadAddr   (loadAddr),
      .loadData   (loadData),
      .loadLength (loadLength),
      .linkIn     (linkIn),
      .wready     (wready),
      .linkOut    (linkOut)
   );

   `include "tbNodeTasks.svh"

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   initial begin
      #(testCycles * period + margin);
      $display("Watchdog expired after %0d cycles of tests", testCycles);
      $display("*** FAILED ***");
      $finish;
   end

   // No port destination, so the links stay quiet
   task automatic idleTest();
      progBuf[0] = movI(dstAcc, litF(5));
      progBuf[1] = aluI(kAdd, litF(3));
      progBuf[2] = movI(dstNil, fAcc);
      progBuf[3] = aluI(kAdd, fLeft);  // Blocks with rready low
      loadProgram(4);
      repeat (12) begin
         @(negedge clk);
         checkDir("linkOut.write", linkOut.write, '0);
         checkDir("linkOut.read", linkOut.read, '0);
         checkValue("linkOut.out", linkOut.out, '0);
      end
   endtask

   task automatic literalWriteTest();
      int i;
      progBuf[0] = movI(dstRight, litF(123));
      progBuf[1] = movI(dstRight, litF(-45));
      loadProgram(2);
      for (i = 0; i < 6; i++) begin
         awaitWrite(dirRight, (i % 2 == 0) ? valueT'(123) : valueT'(-45), i);
      end
   endtask

   task automatic addReadTest();
      int    i;
      int    accM;
      valueT v;
      accM = 0;
      progBuf[0] = aluI(kAdd, fLeft);
      progBuf[1] = movI(dstDown, fAcc);
      loadProgram(2);
      for (i = 0; i < 6; i++) begin
         v = valueT'(randValue());
         offerWord(0, v, (i % 3) * 2);
         accM = satModel(accM + int'(v));
         awaitWrite(dirDown, valueT'(accM), i % 2);
      end
   endtask

   task automatic saturationTest();
      int round;
      int pass;
      int a;
      int b;
      int c;
      int accM;
      int bakM;
      int t;
      for (round = 0; round < 4; round++) begin
         if (round == 0) begin
            a = 900;  // Clamps at the upper limit
            b = -900;
            c = 500;
         end else if (round == 1) begin
            a = -900;  // Clamps at the lower limit
            b = 900;
            c = -500;
         end else begin
            a = randValue();
            b = randValue();
            c = randValue();
         end
         progBuf[0]  = aluI(kAdd, litF(a));
         progBuf[1]  = movI(dstUp, fAcc);
         progBuf[2]  = aluI(kSub, litF(b));
         progBuf[3]  = movI(dstUp, fAcc);
         progBuf[4]  = aluI(kAdd, litF(c));
         progBuf[5]  = movI(dstUp, fAcc);
         progBuf[6]  = negI;
         progBuf[7]  = movI(dstUp, fAcc);
         progBuf[8]  = savI;
         progBuf[9]  = aluI(kSub, fAcc);
         progBuf[10] = movI(dstUp, fAcc);
         progBuf[11] = swpI;
         progBuf[12] = movI(dstUp, fAcc);
         loadProgram(13);
         accM = 0;
         bakM = 0;
         for (pass = 0; pass < 2; pass++) begin
            accM = satModel(accM + a);
            awaitWrite(dirUp, valueT'(accM), (pass + round) % 3);
            accM = satModel(accM - b);
            awaitWrite(dirUp, valueT'(accM), 0);
            accM = satModel(accM + c);
            awaitWrite(dirUp, valueT'(accM), 1);
            accM = satModel(-accM);
            awaitWrite(dirUp, valueT'(accM), 0);
            bakM = accM;
            accM = 0;
            awaitWrite(dirUp, valueT'(accM), 0);
            t    = accM;
            accM = bakM;
            bakM = t;
            awaitWrite(dirUp, valueT'(accM), 0);
         end
      end
   endtask

   // Markers in the 900s only appear if a jump went wrong
   task automatic controlFlowTest();
      int i;
      progBuf[0]  = movI(dstAcc, litF(0));
      progBuf[1]  = jumpI(jJez, 3);
      progBuf[2]  = movI(dstLeft, litF(901));
      progBuf[3]  = jumpI(jJnz, 2);
      progBuf[4]  = movI(dstLeft, litF(1));
      progBuf[5]  = movI(dstAcc, litF(7));
      progBuf[6]  = jumpI(jJlz, 2);
      progBuf[7]  = jumpI(jJgz, 9);
      progBuf[8]  = movI(dstLeft, litF(902));
      progBuf[9]  = negI;
      progBuf[10] = jumpI(jJgz, 2);
      progBuf[11] = jumpI(jJlz, 13);
      progBuf[12] = movI(dstLeft, litF(903));
      progBuf[13] = movI(dstLeft, fAcc);
      loadProgram(14);
      for (i = 0; i < 2; i++) begin  // Two passes through the loop
         awaitWrite(dirLeft, valueT'(1), 0);
         awaitWrite(dirLeft, valueT'(-7), 0);
         checkPc("pc", u_nodeCore.pc, pcT'(0));  // Last word wraps to 0
      end
      progBuf[0] = movI(dstAcc, litF(3));
      progBuf[1] = jumpI(jJez, 0);
      progBuf[2] = jumpI(jJnz, 4);
      progBuf[3] = movI(dstLeft, litF(904));
      progBuf[4] = movI(dstLeft, litF(10));
      progBuf[5] = aluI(kJro, litF(9));    // Clamps to the last word
      progBuf[6] = movI(dstLeft, litF(905));
      progBuf[7] = movI(dstLeft, litF(12));
      progBuf[8] = aluI(kJro, litF(-20));  // Clamps to word 0
      progBuf[9] = jumpI(jJmp, 7);
      loadProgram(10);
      for (i = 0; i < 2; i++) begin
         awaitWrite(dirLeft, valueT'(10), 1);
         awaitWrite(dirLeft, valueT'(12), 0);
      end
   endtask

   initial begin
      int total;
      valueErrs  = 0;
      dirErrs    = 0;
      pcErrs     = 0;
      waitErrs   = 0;
      lfsrState  = 32'hf1f9;
      rst        = 1'b1;
      load       = 1'b0;
      loadAddr   = '0;
      loadData   = '0;
      loadLength = '0;
      linkIn     = '0;
      wready     = '0;
      repeat (2) @(posedge clk);
      idleTest();
      literalWriteTest();
      addReadTest();
      saturationTest();
      controlFlowTest();
      @(negedge clk);
      total = valueErrs + dirErrs + pcErrs + waitErrs;
      $display("Errors: value %0d, link %0d, pc %0d, timeout %0d",
               valueErrs, dirErrs, pcErrs, waitErrs);
      if (total == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
